// ==== link_pkg.sv ====
// **********************************************************
// Link PHY self-test shared definitions
// Lane word format, status and error codes, timing constants
// **********************************************************
`default_nettype none

package link_pkg;

   // Timing constants in FCLK cycles
   localparam int RESET_HOLD    = 16;
   localparam int TRAIN_LOCK    = 8;
   localparam int TRAIN_TIMEOUT = 256;

   localparam int HOLD_W = $clog2(RESET_HOLD);
   localparam int LOCK_W = $clog2(TRAIN_LOCK);
   localparam int TMO_W  = $clog2(TRAIN_TIMEOUT);

   typedef logic [63:0]       payload_t;
   typedef logic [HOLD_W-1:0] hold_cnt_t;
   typedef logic [LOCK_W-1:0] lock_cnt_t;
   typedef logic [TMO_W-1:0]  tmo_cnt_t;

   typedef enum logic [1:0] {
      LANE_IDLE  = 2'd0,
      LANE_TRAIN = 2'd1,
      LANE_DATA  = 2'd2
   } lane_kind_t;

   // 67-bit word on the parallel lane
   typedef struct packed {
      lane_kind_t kind;
      payload_t   payload;
      logic       parity;
   } lane_word_t;

   // One-hot, doubles as the link FSM state
   typedef enum logic [3:0] {
      ST_RESET = 4'b0001,
      ST_TRAIN = 4'b0010,
      ST_UP    = 4'b0100,
      ST_FAULT = 4'b1000
   } link_status_t;

   typedef enum logic [3:0] {
      EC_NONE    = 4'd0,
      EC_PARITY  = 4'd1,
      EC_TIMEOUT = 4'd2
   } link_ecode_t;

   // Even parity over kind and payload
   function automatic logic lane_parity(input lane_kind_t kind, input payload_t payload);
      return ^{kind, payload};
   endfunction

endpackage

`default_nettype wire

// ==== reset_seq.sv ====
// **********************************************************
// Reset sequencer
// Synchronizes ARSTn and holds the core reset for a fixed count
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module reset_seq
   import link_pkg::*;
(
   input  logic FCLK,
   input  logic ARSTn,
   output logic core_rst_n
);

   logic [1:0] rst_sync;
   hold_cnt_t  hold_cnt;
   logic       hold_done;

   // Last count value reached while the synchronized reset is released
   assign hold_done = rst_sync[1] && (hold_cnt == hold_cnt_t'(RESET_HOLD - 1));

   // Two-flop synchronizer, cleared straight away by ARSTn
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         rst_sync <= 2'b00;
      end else begin
         rst_sync <= {rst_sync[0], 1'b1};
      end
   end

   // Hold counter, core reset asserted asynchronously and released on a clock edge
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         hold_cnt   <= '0;
         core_rst_n <= 1'b0;
      end else begin
         if (rst_sync[1] && !core_rst_n && !hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
         end
         if (hold_done) begin
            core_rst_n <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== count_source.sv ====
// **********************************************************
// Counting traffic source
// Offers an incrementing 64-bit word under valid/ready
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module count_source
   import link_pkg::*;
(
   input  logic     FCLK,
   input  logic     core_rst_n,
   input  logic     tx_ready,
   output payload_t tx_data,
   output logic     tx_valid
);

   payload_t tx_data_nxt;
   logic     tx_xfer;

   assign tx_xfer = tx_valid && tx_ready;

   // Hold the offered word until it is taken
   assign tx_data_nxt = tx_xfer ? tx_data + 64'h1 : tx_data;

   // Valid rises on the first cycle out of reset and stays high
   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= 1'b1;
      end
   end

   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         tx_data <= '0;
      end else begin
         tx_data <= tx_data_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== link_ctrl.sv ====
// **********************************************************
// Link controller
// Training, lock detection, timeout and fault handling
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module link_ctrl
   import link_pkg::*;
(
   input  logic         FCLK,
   input  logic         core_rst_n,
   input  logic         enable,
   input  lane_kind_t   rx_kind,
   input  logic         rx_strobe,
   input  logic         parity_bad,
   output lane_kind_t   tx_kind,
   output logic         tx_ready,
   output link_status_t status,
   output link_ecode_t  ecode
);

   link_status_t state;
   link_status_t state_nxt;
   link_ecode_t  ecode_nxt;
   lock_cnt_t    lock_cnt;
   lock_cnt_t    lock_cnt_nxt;
   tmo_cnt_t     tmo_cnt;
   tmo_cnt_t     tmo_cnt_nxt;
   logic         train_good;

   // A clean training word from the partner
   assign train_good = rx_strobe && (rx_kind == LANE_TRAIN);

   always_comb begin
      state_nxt    = state;
      ecode_nxt    = ecode;
      lock_cnt_nxt = '0;
      tmo_cnt_nxt  = '0;
      if (!enable) begin
         state_nxt = ST_RESET;
         ecode_nxt = EC_NONE;
      end else begin
         case (state)
            ST_RESET: begin
               state_nxt = ST_TRAIN;
            end
            ST_TRAIN: begin
               tmo_cnt_nxt = tmo_cnt + 1'b1;
               // Lock count restarts on anything but a good TRAIN word
               if (train_good) begin
                  lock_cnt_nxt = lock_cnt + 1'b1;
               end
               if (parity_bad) begin
                  state_nxt = ST_FAULT;
                  ecode_nxt = EC_PARITY;
               end else if (train_good && lock_cnt == lock_cnt_t'(TRAIN_LOCK - 1)) begin
                  state_nxt = ST_UP;
               end else if (tmo_cnt == tmo_cnt_t'(TRAIN_TIMEOUT - 1)) begin
                  state_nxt = ST_FAULT;
                  ecode_nxt = EC_TIMEOUT;
               end
            end
            ST_UP: begin
               if (parity_bad) begin
                  state_nxt = ST_FAULT;
                  ecode_nxt = EC_PARITY;
               end
            end
            ST_FAULT: begin
               // Stays here until enable is dropped
               state_nxt = ST_FAULT;
            end
            default: begin
               state_nxt = ST_RESET;
            end
         endcase
      end
   end

   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         state    <= ST_RESET;
         ecode    <= EC_NONE;
         lock_cnt <= '0;
         tmo_cnt  <= '0;
      end else begin
         state    <= state_nxt;
         ecode    <= ecode_nxt;
         lock_cnt <= lock_cnt_nxt;
         tmo_cnt  <= tmo_cnt_nxt;
      end
   end

   // Lane turns IDLE words into DATA when a transfer happens
   assign tx_kind  = (state == ST_TRAIN) ? LANE_TRAIN : LANE_IDLE;
   assign tx_ready = (state == ST_UP);
   assign status   = state;

endmodule

`default_nettype wire

// ==== link_lane.sv ====
// **********************************************************
// Lane datapath
// Builds and checks lane words, delivers received payload
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module link_lane
   import link_pkg::*;
(
   input  logic       FCLK,
   input  logic       core_rst_n,
   input  lane_kind_t tx_kind,
   input  payload_t   tx_data,
   input  logic       tx_fire,
   output lane_word_t lane_out,
   input  lane_word_t lane_in,
   input  logic       up,
   output lane_kind_t rx_kind,
   output logic       rx_strobe,
   output logic       parity_bad,
   output payload_t   rx_data,
   output logic       rx_valid
);

   lane_kind_t tx_kind_sel;
   payload_t   tx_payload_sel;
   lane_word_t rx_word;
   logic       rx_live;
   logic       parity_ok;

   // A transfer always goes out as DATA, otherwise payload is zero
   assign tx_kind_sel    = tx_fire ? LANE_DATA : tx_kind;
   assign tx_payload_sel = tx_fire ? tx_data : '0;

   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         lane_out <= '{kind: LANE_IDLE, payload: '0, parity: 1'b0};
         rx_live  <= 1'b0;
      end else begin
         lane_out <= '{kind: tx_kind_sel,
                       payload: tx_payload_sel,
                       parity: lane_parity(tx_kind_sel, tx_payload_sel)};
         rx_live  <= 1'b1;
      end
   end

   // Incoming word, qualified by rx_live until the first real capture
   always_ff @(posedge FCLK) begin
      rx_word <= lane_in;
   end

   assign parity_ok  = (lane_parity(rx_word.kind, rx_word.payload) == rx_word.parity);
   assign rx_strobe  = rx_live && parity_ok;
   assign parity_bad = rx_live && !parity_ok;
   assign rx_kind    = rx_word.kind;

   // Payload reaches the user only on a clean DATA word while up
   assign rx_valid = rx_strobe && up && (rx_word.kind == LANE_DATA);
   assign rx_data  = rx_word.payload;

endmodule

`default_nettype wire

// ==== count_check.sv ====
// **********************************************************
// Counting checker
// Compares received words to a local count, sticky error
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module count_check
   import link_pkg::*;
(
   input  logic     FCLK,
   input  logic     core_rst_n,
   input  payload_t rx_data,
   input  logic     rx_valid,
   output logic     data_error
);

   payload_t ref_cnt;
   payload_t ref_cnt_nxt;
   logic     data_error_nxt;

   // Expected value moves on with every delivered word
   assign ref_cnt_nxt = rx_valid ? ref_cnt + 64'h1 : ref_cnt;

   // Once set, only core reset clears it
   assign data_error_nxt = data_error || (rx_valid && (rx_data != ref_cnt));

   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         ref_cnt <= '0;
      end else begin
         ref_cnt <= ref_cnt_nxt;
      end
   end

   always_ff @(posedge FCLK or negedge core_rst_n) begin
      if (!core_rst_n) begin
         data_error <= 1'b0;
      end else begin
         data_error <= data_error_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== phy_selftest_top.sv ====
// **********************************************************
// Link PHY self-test top level
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module phy_selftest_top
   import link_pkg::*;
(
   input  logic         FCLK,
   input  logic         ARSTn,
   input  logic         enable,
   input  lane_word_t   lane_in,
   output lane_word_t   lane_out,
   output payload_t     rx_data,
   output logic         rx_valid,
   output link_status_t status,
   output link_ecode_t  ecode,
   output logic         data_error
);

   logic       core_rst_n;
   payload_t   tx_data;
   logic       tx_valid;
   logic       tx_ready;
   logic       tx_fire;
   lane_kind_t tx_kind;
   lane_kind_t rx_kind;
   logic       rx_strobe;
   logic       parity_bad;

   // Single point where the transmit handshake is resolved
   assign tx_fire = tx_valid & tx_ready;

   reset_seq reset_seq_i (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .core_rst_n(core_rst_n)
   );

   count_source count_source_i (
      .FCLK      (FCLK),
      .core_rst_n(core_rst_n),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid)
   );

   link_ctrl link_ctrl_i (
      .FCLK      (FCLK),
      .core_rst_n(core_rst_n),
      .enable    (enable),
      .rx_kind   (rx_kind),
      .rx_strobe (rx_strobe),
      .parity_bad(parity_bad),
      .tx_kind   (tx_kind),
      .tx_ready  (tx_ready),
      .status    (status),
      .ecode     (ecode)
   );

   // tx_ready is high exactly in ST_UP
   link_lane link_lane_i (
      .FCLK      (FCLK),
      .core_rst_n(core_rst_n),
      .tx_kind   (tx_kind),
      .tx_data   (tx_data),
      .tx_fire   (tx_fire),
      .lane_out  (lane_out),
      .lane_in   (lane_in),
      .up        (tx_ready),
      .rx_kind   (rx_kind),
      .rx_strobe (rx_strobe),
      .parity_bad(parity_bad),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

   count_check count_check_i (
      .FCLK      (FCLK),
      .core_rst_n(core_rst_n),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .data_error(data_error)
   );

endmodule

`default_nettype wire

// ==== phy_selftest_chk.sv ====
// **********************************************************
// Link protocol assertions, bound into the self-test top
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module phy_selftest_chk
   import link_pkg::*;
(
   input logic         FCLK,
   input logic         ARSTn,
   input logic         tx_ready,
   input link_status_t status,
   input lane_word_t   lane_out
);

   // Transmit side only accepts data while the link is up
   ready_only_up: assert property (@(posedge FCLK) disable iff (!ARSTn)
      tx_ready |-> status == ST_UP)
      else $error("tx_ready high outside ST_UP");

   // Lane word is registered, so it follows the state one cycle late
   data_only_up: assert property (@(posedge FCLK) disable iff (!ARSTn)
      lane_out.kind == LANE_DATA |-> $past(status) == ST_UP)
      else $error("DATA word sent outside ST_UP");

   status_onehot: assert property (@(posedge FCLK) disable iff (!ARSTn)
      $onehot(status))
      else $error("status is not one-hot");

endmodule

`default_nettype wire

// ==== tb_phy_selftest.sv ====
// **********************************************************
// Link PHY self-test testbench
// Loopback with fault injection, stream reference and watchdog
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_phy_selftest
   import link_pkg::*;
();

   // About 1200 cycles of tests at 10 ns, with margin
   localparam int WATCHDOG_NS = 20000;

   typedef enum int {LB_CLEAN, LB_PARITY, LB_DATAERR, LB_STUCK} loop_mode_t;

   logic         FCLK;
   logic         ARSTn;
   logic         enable;
   lane_word_t   lane_in;
   lane_word_t   lane_out;
   payload_t     rx_data;
   logic         rx_valid;
   link_status_t status;
   link_ecode_t  ecode;
   logic         data_error;

   loop_mode_t   lb_mode;
   logic         flip_pending;
   int           flip_pos;
   logic         corrupt_set;
   payload_t     corrupt_val;
   payload_t     corrupt_mask;
   logic         resync;
   payload_t     base;
   payload_t     last_rx;
   int           n_since;
   int           rx_count;
   int           chk_cnt;
   int           err_cnt;
   logic [31:0]  rng_state;

   phy_selftest_top phy_selftest_top_i (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .enable    (enable),
      .lane_in   (lane_in),
      .lane_out  (lane_out),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .status    (status),
      .ecode     (ecode),
      .data_error(data_error)
   );

   bind phy_selftest_top phy_selftest_chk phy_selftest_chk_i (
      .FCLK    (FCLK),
      .ARSTn   (ARSTn),
      .tx_ready(tx_ready),
      .status  (status),
      .lane_out(lane_out)
   );

   always #5 FCLK = ~FCLK;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // The n-th delivered word of a counting stream is n
   function automatic payload_t expected_word(input int unsigned n);
      return payload_t'(n);
   endfunction

   task automatic report_err(input string msg);
      err_cnt++;
      $display("ERR %0t ns: %s", $time, msg);
   endtask

   // Lane loopback, optionally corrupting one DATA word
   always @(negedge FCLK) begin : loopback
      lane_word_t w;
      w = lane_out;
      if (lb_mode == LB_STUCK) begin
         w = '{kind: LANE_IDLE, payload: '0, parity: 1'b0};
      end else if (lb_mode != LB_CLEAN && flip_pending && w.kind == LANE_DATA) begin
         w.payload[flip_pos] = ~w.payload[flip_pos];
         if (lb_mode == LB_DATAERR) begin
            w.parity     = ^{w.kind, w.payload};
            corrupt_val  = lane_out.payload;
            corrupt_mask = 64'h1 << flip_pos;
            corrupt_set  = 1'b1;
         end
         flip_pending = 1'b0;
      end
      lane_in = w;
   end

   // Compare every delivered word with the reference
   always @(negedge FCLK) begin : rx_compare
      payload_t exp_clean;
      payload_t exp;
      if (ARSTn && rx_valid) begin
         if (resync) begin
            assert (rx_data > last_rx && rx_data - last_rx <= 64'd8)
               else report_err($sformatf("stream resumed at %0d after %0d", rx_data, last_rx));
            base    = rx_data;
            n_since = 0;
            resync  = 1'b0;
         end
         exp_clean = base + expected_word(n_since);
         exp       = exp_clean;
         if (corrupt_set && exp_clean == corrupt_val) begin
            exp = exp_clean ^ corrupt_mask;
         end
         chk_cnt++;
         assert (rx_data == exp)
            else report_err($sformatf("rx_data %0h, expected %0h", rx_data, exp));
         last_rx = exp_clean;
         n_since++;
         rx_count++;
      end
   end

   // Reset with enable low, checking the idle outputs throughout
   task automatic apply_reset();
      @(negedge FCLK);
      ARSTn        = 1'b0;
      enable       = 1'b0;
      flip_pending = 1'b0;
      corrupt_set  = 1'b0;
      resync       = 1'b0;
      base         = '0;
      n_since      = 0;
      repeat (2) @(negedge FCLK);
      ARSTn = 1'b1;
      repeat (RESET_HOLD + 6) begin
         @(negedge FCLK);
         chk_cnt++;
         assert (status == ST_RESET && ecode == EC_NONE && !rx_valid && !data_error
                 && lane_out.kind == LANE_IDLE && lane_out.payload == '0)
            else report_err("outputs not idle around reset");
      end
   endtask

   task automatic train_up();
      int n;
      n = 0;
      while (status != ST_UP && n < TRAIN_TIMEOUT) begin
         @(negedge FCLK);
         assert (ecode == EC_NONE) else report_err("ecode set during training");
         n++;
      end
      chk_cnt++;
      assert (status == ST_UP) else report_err("link did not reach ST_UP");
   endtask

   task automatic wait_status(input link_status_t target, input int limit);
      int n;
      n = 0;
      while (status != target && n < limit) begin
         @(negedge FCLK);
         n++;
      end
      chk_cnt++;
      assert (status == target)
         else report_err($sformatf("status %b, expected %b", status, target));
   endtask

   task automatic wait_deliveries(input int k);
      int target;
      int n;
      target = rx_count + k;
      n      = 0;
      while (rx_count < target && n < 4 * k + 64) begin
         @(negedge FCLK);
         n++;
      end
      assert (rx_count >= target) else report_err("receive stream stalled");
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

   initial begin : main_seq
      int gap;
      int n;
      FCLK         = 1'b0;
      ARSTn        = 1'b0;
      enable       = 1'b0;
      lane_in      = '{kind: LANE_IDLE, payload: '0, parity: 1'b0};
      lb_mode      = LB_CLEAN;
      flip_pending = 1'b0;
      flip_pos     = 0;
      corrupt_set  = 1'b0;
      corrupt_val  = '0;
      corrupt_mask = '0;
      resync       = 1'b0;
      base         = '0;
      last_rx      = '0;
      n_since      = 0;
      rx_count     = 0;
      chk_cnt      = 0;
      err_cnt      = 0;
      rng_state    = 32'h925e_f511;

      // Reset, training and a clean stream
      apply_reset();
      enable = 1'b1;
      train_up();
      wait_deliveries(500);
      repeat (2) @(negedge FCLK);
      assert (data_error == 1'b0) else report_err("data_error set on clean stream");

      // Parity fault, then retrain after an enable gap
      rng_state    = lcg_next(rng_state);
      flip_pos     = int'(rng_state[29:24]);
      lb_mode      = LB_PARITY;
      flip_pending = 1'b1;
      wait_status(ST_FAULT, 32);
      assert (ecode == EC_PARITY) else report_err("ecode is not EC_PARITY");
      resync = 1'b1;
      repeat (10) begin
         @(negedge FCLK);
         assert (!rx_valid) else report_err("rx_valid while in ST_FAULT");
      end
      rng_state = lcg_next(rng_state);
      gap       = 2 + int'(rng_state[19:16]);
      enable    = 1'b0;
      repeat (gap) @(negedge FCLK);
      assert (status == ST_RESET && ecode == EC_NONE)
         else report_err("enable low did not clear the fault");
      lb_mode = LB_CLEAN;
      enable  = 1'b1;
      train_up();
      wait_deliveries(50);

      // Stuck lane ends in a training timeout
      lb_mode = LB_STUCK;
      apply_reset();
      enable = 1'b1;
      n      = 0;
      while (status != ST_FAULT && n < TRAIN_TIMEOUT + 16) begin
         @(negedge FCLK);
         assert (status != ST_UP) else report_err("ST_UP with the lane stuck at IDLE");
         n++;
      end
      assert (status == ST_FAULT && ecode == EC_TIMEOUT)
         else report_err($sformatf("no timeout fault, status %b ecode %0d", status, ecode));

      // Payload flip with good parity reaches the checker
      lb_mode = LB_CLEAN;
      apply_reset();
      enable = 1'b1;
      train_up();
      wait_deliveries(20);
      assert (data_error == 1'b0) else report_err("data_error set before corruption");
      rng_state    = lcg_next(rng_state);
      flip_pos     = int'(rng_state[29:24]);
      lb_mode      = LB_DATAERR;
      flip_pending = 1'b1;
      wait_deliveries(20);
      assert (corrupt_set && data_error) else report_err("data_error not raised");
      wait_deliveries(50);
      assert (data_error) else report_err("data_error did not stay set");
      lb_mode = LB_CLEAN;
      apply_reset();

      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== phy_selftest_top.f ====
link_pkg.sv
reset_seq.sv
count_source.sv
link_ctrl.sv
link_lane.sv
count_check.sv
phy_selftest_top.sv
phy_selftest_chk.sv
tb_phy_selftest.sv

// ==== Makefile ====
# Verilator build and run for the link PHY self-test
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_phy_selftest
FILELIST  := phy_selftest_top.f
OBJDIR    := obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
